// File: bench/fdc_assert.sv
// protocol assertions on the FDC core that bind attaches to fdc_top
`timescale 1ns/1ps

module fdc_assert (
	input logic                  clk_sys,
	input logic                  reset,
	input fdc_pkg::host_strobe_t i_strobe,
	input fdc_pkg::host_byte_t   i_msr,
	input logic [1:0]            i_busy,
	input logic [1:0]            i_int_pending
);

	int fail_count = 0; // failed assertions so far

	// idle with only RQM set right after reset
	a_reset_msr: assert property (@(posedge clk_sys) $fell(reset) |-> i_msr == 8'h80)
		else begin
			$error("status register is not 80h after reset");
			fail_count++;
		end

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		!(i_strobe.cmd_wr && i_strobe.data_rd))
		else begin
			$error("command write and data read pulsed in the same clock");
			fail_count++;
		end

	for (genvar d = 0; d < 2; d++) begin : g_drive
		a_busy_end: assert property (@(posedge clk_sys) disable iff (reset)
			$fell(i_busy[d]) |-> $rose(i_int_pending[d])) // seek end is the only exit
			else begin
				$error("drive %0d left busy without raising its interrupt flag", d);
				fail_count++;
			end
	end

endmodule

bind fdc_top fdc_assert u_assert (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.i_strobe      (strobe),
	.i_msr         (msr),
	.i_busy        ({drive_state[1].busy, drive_state[0].busy}),
	.i_int_pending ({drive_state[1].int_pending, drive_state[0].int_pending})
);

// File: bench/fdc_checker.sv
// testbench checker for the FDC core: samples every data register read and compares with the queue
`timescale 1ns/1ps

module fdc_checker (
	input logic                clk_sys,
	input logic                i_a0,
	input logic                i_rd_n,
	input logic                i_wr_n,
	input fdc_pkg::host_byte_t i_dout
);
	import fdc_pkg::*;

	string      exp_name [$];  // test of each queued byte
	host_byte_t exp_value [$];
	string      test_name = "none";
	int         rd_cycles = 0;
	int         check_count = 0;
	int         error_count = 0;
	int         test_checks = 0;
	int         test_errors = 0;
	int         tests_run = 0;
	int         tests_failed = 0;

	task automatic push_expect(input string name, input host_byte_t value);
		exp_name.push_back(name);
		exp_value.push_back(value);
	endtask

	task automatic check_byte(input string name, input host_byte_t exp, input host_byte_t act);
		check_count++;
		test_checks++;
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %02h actual %02h", name, exp, act);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %-16s %s, %0d checks", test_name, (test_errors != 0) ? "failed" : "ok",
			test_checks);
	endtask

	task automatic report_counts();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			check_count, error_count);
	endtask

	// byte is stable from the second clock of the read, take it on the fourth
	always @(posedge clk_sys) begin
		if (!i_rd_n && i_wr_n && i_a0) begin
			rd_cycles++;
			if (rd_cycles == 4) begin
				if (exp_value.size() == 0) begin
					$display("data register read while no result byte was expected");
					error_count++;
					test_errors++;
				end else begin
					check_byte(exp_name.pop_front(), exp_value.pop_front(), i_dout);
				end
			end
		end else begin
			rd_cycles = 0;
		end
	end

endmodule

// File: bench/fdc_tb.sv
// testbench top of the FDC core that runs the command set over the host bus and queues bytes
`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_tb;
	import fdc_pkg::*;

	localparam int POLL_LIMIT = 4000; // status reads per wait

	logic        clk_sys;
	logic        reset;
	logic        a0;
	logic        rd_n;
	logic        wr_n;
	host_byte_t  din;
	host_byte_t  dout;
	drive_info_t drive_info [2];
	cyl_t        m_pcn [2];   // model of each drive
	cyl_t        m_ncn [2];
	logic        m_flag [2];  // seek end pending
	int unsigned lcg_state = 75;

	fdc_top #(
		.CYCLES_PER_MS (20)
	) UUT (
		.clk_sys (clk_sys),
		.reset   (reset),
		.i_a0    (a0),
		.i_rd_n  (rd_n),
		.i_wr_n  (wr_n),
		.i_din   (din),
		.i_drive (drive_info),
		.o_dout  (dout)
	);

	fdc_checker u_checker (
		.clk_sys (clk_sys),
		.i_a0    (a0),
		.i_rd_n  (rd_n),
		.i_wr_n  (wr_n),
		.i_dout  (dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// result byte idx of a command as the model predicts it
	function automatic host_byte_t predict_result(input host_byte_t op, input int d,
		input int idx);
		int p;
		p = m_flag[0] ? 0 : (m_flag[1] ? 1 : -1); // drive 0 first
		if (op == `FDC_OP_SENSE_DRIVE)
			return {1'b0, drive_info[d].ready & drive_info[d].write_protect,
				drive_info[d].available,
				drive_info[d].ready & (m_pcn[d] == 8'h00),
				drive_info[d].ready & drive_info[d].two_sided, 2'b00, d[0]};
		if (op != `FDC_OP_SENSE_INT || p < 0)
			return `FDC_ST0_INVALID;
		if (idx == 1)
			return m_pcn[p];
		if (m_pcn[p] == m_ncn[p] && drive_info[p].ready)
			return `FDC_ST0_SEEK_END + 8'(p);
		return `FDC_ST0_SEEK_ABN + 8'(p);
	endfunction

	task automatic end_run(input logic timed_out);
		int missing;
		int assert_fails;
		missing      = u_checker.exp_value.size();
		assert_fails = UUT.u_assert.fail_count;
		u_checker.report_counts();
		if (missing != 0)
			$display("%0d expected result bytes were never read", missing);
		if (assert_fails != 0)
			$display("%0d protocol assertions failed", assert_fails);
		if (timed_out || u_checker.error_count != 0 || missing != 0 ||
			assert_fails != 0) begin
			$display("SIMULATION FAILED");
		end else begin
			$display("SIMULATION PASSED");
		end
		$finish;
	endtask

	// ==========================================================================
	// host bus
	// ==========================================================================
	task automatic read_status(output host_byte_t s);
		@(negedge clk_sys);
		a0   = 1'b0;
		rd_n = 1'b0;
		repeat (4) @(negedge clk_sys);
		s    = dout;
		rd_n = 1'b1;
	endtask

	task automatic wait_status(input host_byte_t mask, input host_byte_t value,
		input string what);
		host_byte_t s;
		int         n;
		n = 0;
		read_status(s);
		while ((s & mask) != value && n < POLL_LIMIT) begin
			read_status(s);
			n++;
		end
		if ((s & mask) != value) begin
			$display("timeout while waiting for %s, status register %02h", what, s);
			end_run(1'b1);
		end
	endtask

	task automatic write_byte(input host_byte_t b);
		wait_status(8'hC0, 8'h80, "RQM before a write");
		@(negedge clk_sys);
		a0   = 1'b1;
		din  = b;
		wr_n = 1'b0;
		repeat (4) @(negedge clk_sys);
		wr_n = 1'b1;
	endtask

	task automatic read_result(input string name, input host_byte_t expected);
		wait_status(8'hC0, 8'hC0, "RQM and DIO before a read");
		u_checker.push_expect(name, expected);
		@(negedge clk_sys);
		a0   = 1'b1;
		rd_n = 1'b0;
		repeat (4) @(negedge clk_sys);
		rd_n = 1'b1;
	endtask

	// ==========================================================================
	// commands, each one updating the model
	// ==========================================================================
	task automatic position(input int d, input cyl_t target);
		logic ok;
		ok = (target == 8'h00) || (drive_info[d].ready && drive_info[d].motor &&
			target < drive_info[d].track_count);
		write_byte(`FDC_OP_SEEK);
		write_byte(8'(d));
		write_byte(target);
		m_ncn[d] = target;
		if (ok)
			m_pcn[d] = target; // rejected seeks leave the head
		m_flag[d] = 1'b1;
		wait_status(8'h01 << d, 8'h00, "seek end");
	endtask

	task automatic sense_interrupt(input string name);
		int p;
		p = m_flag[0] ? 0 : (m_flag[1] ? 1 : -1);
		write_byte(`FDC_OP_SENSE_INT);
		read_result(name, predict_result(`FDC_OP_SENSE_INT, 0, 0));
		if (p >= 0) begin
			read_result(name, predict_result(`FDC_OP_SENSE_INT, 0, 1));
			m_flag[p] = 1'b0;
		end
	endtask

	task automatic sense_drive(input string name, input int d);
		write_byte(`FDC_OP_SENSE_DRIVE);
		write_byte(8'(d));
		m_flag[0] = 1'b0; // both flags drop
		m_flag[1] = 1'b0;
		read_result(name, predict_result(`FDC_OP_SENSE_DRIVE, d, 0));
	endtask

	initial begin
		host_byte_t  s;
		int unsigned r;
		reset = 1'b1;
		a0    = 1'b0;
		rd_n  = 1'b1;
		wr_n  = 1'b1;
		din   = 8'h00;
		for (int d = 0; d < 2; d++) begin
			drive_info[d] = {1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 8'd80};
			m_pcn[d]      = 8'h00;
			m_ncn[d]      = 8'h00;
			m_flag[d]     = 1'b0;
		end
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;

		u_checker.start_test("reset_state");
		read_status(s);
		u_checker.check_byte("reset_state", 8'h80, s);
		sense_interrupt("reset_state");
		u_checker.end_test();

		u_checker.start_test("invalid_opcode");
		write_byte(8'h0A);
		read_result("invalid_opcode", predict_result(8'h0A, 0, 0));
		read_status(s);
		u_checker.check_byte("invalid_opcode", 8'h80, s);
		u_checker.end_test();

		u_checker.start_test("seek_valid");
		write_byte(`FDC_OP_SPECIFY);
		write_byte(8'hC1); // step rate C
		write_byte(8'h02);
		m_flag[0] = 1'b0;
		m_flag[1] = 1'b0;
		for (int d = 0; d < 2; d++) begin
			write_byte(`FDC_OP_RECALIBRATE);
			write_byte(8'(d));
			m_ncn[d]  = 8'h00;
			m_pcn[d]  = 8'h00;
			m_flag[d] = 1'b1;
			wait_status(8'h01 << d, 8'h00, "recalibrate end");
			sense_interrupt("seek_valid");
			repeat (2) begin
				position(d, 8'(1 + lcg_next() % 79));
				sense_interrupt("seek_valid");
			end
		end
		u_checker.end_test();

		u_checker.start_test("seek_reject");
		position(0, 8'd80); // one past the last track
		sense_interrupt("seek_reject");
		drive_info[1].ready = 1'b0;
		position(1, 8'(1 + lcg_next() % 79));
		sense_interrupt("seek_reject");
		drive_info[1].ready = 1'b1;
		u_checker.end_test();

		u_checker.start_test("sense_priority");
		position(0, 8'(1 + lcg_next() % 79));
		position(1, 8'(1 + lcg_next() % 79));
		sense_interrupt("sense_priority");
		sense_interrupt("sense_priority");
		sense_interrupt("sense_priority"); // nothing left
		u_checker.end_test();

		u_checker.start_test("sense_drive");
		for (int i = 0; i < 8; i++) begin
			if (i >= 4)
				position(i % 2, 8'h00); // head to track 0
			r = lcg_next();
			drive_info[i % 2].ready         = r[0];
			drive_info[i % 2].write_protect = r[1];
			drive_info[i % 2].available     = r[2];
			drive_info[i % 2].two_sided     = r[3];
			sense_drive("sense_drive", i % 2);
		end
		u_checker.end_test();

		end_run(1'b0);
	end

endmodule

// File: fdc_top.f
+incdir+include
verilog/fdc_pkg.sv
verilog/fdc_host_port.sv
verilog/fdc_head_stepper.sv
verilog/fdc_command_fsm.sv
verilog/fdc_top.sv
bench/fdc_checker.sv
bench/fdc_assert.sv
bench/fdc_tb.sv

// File: include/fdc_macros.svh
// constants for the FDC core (status bits, opcodes, status bytes, step timing), include where needed
`ifndef FDC_MACROS_SVH
`define FDC_MACROS_SVH

// ==========================================================================
// main status register bit positions
// ==========================================================================
`define FDC_MSR_D0B 0 // drive 0 seeking
`define FDC_MSR_D1B 1 // drive 1 seeking
`define FDC_MSR_CB  4 // command in progress
`define FDC_MSR_DIO 6 // 1 = controller to host
`define FDC_MSR_RQM 7 // data register ready

// ==========================================================================
// opcodes of the supported commands
// ==========================================================================
`define FDC_OP_SPECIFY     8'h03
`define FDC_OP_SENSE_DRIVE 8'h04
`define FDC_OP_RECALIBRATE 8'h07
`define FDC_OP_SENSE_INT   8'h08
`define FDC_OP_SEEK        8'h0F

// status bytes, drive number is added to the seek ones
`define FDC_ST0_INVALID  8'h80
`define FDC_ST0_SEEK_END 8'h20
`define FDC_ST0_SEEK_ABN 8'hE8

// step timing
`define FDC_CYCLES_PER_MS_DEFAULT 4000 // clocks per step unit
`define FDC_SRT_RESET             4'd4

`endif

// File: verilog/fdc_command_fsm.sv
// command phase of the FDC: opcode decode, parameter bytes, status register and result bytes
`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_command_fsm (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  fdc_pkg::host_strobe_t i_strobe,
	input  fdc_pkg::drive_info_t  i_drive [2],
	input  fdc_pkg::drive_state_t i_drive_state [2],
	output fdc_pkg::seek_cmd_t    o_seek_cmd [2],
	output fdc_pkg::step_rate_t   o_step_rate,
	output fdc_pkg::host_byte_t   o_msr,
	output logic                  o_data_load,
	output fdc_pkg::host_byte_t   o_data_byte
);
	import fdc_pkg::*;

	cmd_state_t   state;
	drive_sel_t   ds;          // drive of the current command
	step_rate_t   srt;
	logic         rqm;
	logic         result_phase;
	logic         seek_ok;
	drive_info_t  sel_info;
	drive_state_t sel_state;
	host_byte_t   st3;

	assign sel_info  = i_drive[ds];
	assign sel_state = i_drive_state[ds];

	// cylinder 0 is always reachable, anything else needs a spinning ready drive
	assign seek_ok = (i_strobe.wdata == 8'h00) ||
		(sel_info.ready && sel_info.motor && (i_strobe.wdata < sel_info.track_count));

	assign st3 = {
		1'b0,
		sel_info.ready & sel_info.write_protect,
		sel_info.available,
		sel_info.ready & (sel_state.pcn == 8'h00), // track 0
		sel_info.ready & sel_info.two_sided,
		1'b0,                                      // head address
		1'b0,                                      // us1
		ds
	};

	// ======================================================================
	// command sequencing
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		o_data_load <= 1'b0;
		for (int i = 0; i < 2; i++) begin
			o_seek_cmd[i].start     <= 1'b0;
			o_seek_cmd[i].reject    <= 1'b0;
			o_seek_cmd[i].clear_int <= 1'b0;
		end

		if (reset) begin
			state <= IDLE;
			ds    <= 1'b0;
			srt   <= `FDC_SRT_RESET;
			rqm   <= 1'b1;
			for (int i = 0; i < 2; i++)
				o_seek_cmd[i].target <= '0;
		end else begin
			// drop RQM for one clock after each accepted transfer
			rqm <= ~(i_strobe.cmd_wr | i_strobe.data_rd);

			case (state)
				IDLE:
				if (i_strobe.cmd_wr) begin
					case (i_strobe.wdata)
						`FDC_OP_SPECIFY: begin
							for (int i = 0; i < 2; i++)
								o_seek_cmd[i].clear_int <= 1'b1;
							state <= SPECIFY_P1;
						end
						`FDC_OP_SENSE_DRIVE: begin
							for (int i = 0; i < 2; i++)
								o_seek_cmd[i].clear_int <= 1'b1;
							state <= SENSE_DRV_P1;
						end
						`FDC_OP_RECALIBRATE: state <= RECAL_P1;
						`FDC_OP_SENSE_INT:   state <= SENSE_INT_ST0;
						`FDC_OP_SEEK:        state <= SEEK_P1;
						default:             state <= INVALID_RES;
					endcase
				end

				SPECIFY_P1:
				if (i_strobe.cmd_wr) begin
					srt   <= i_strobe.wdata[7:4]; // HUT not used
					state <= SPECIFY_P2;
				end

				SPECIFY_P2:
				if (i_strobe.cmd_wr)
					state <= IDLE; // HLT/ND byte, nothing kept

				RECAL_P1:
				if (i_strobe.cmd_wr) begin
					ds                                   <= i_strobe.wdata[0];
					o_seek_cmd[i_strobe.wdata[0]].start  <= 1'b1;
					o_seek_cmd[i_strobe.wdata[0]].target <= 8'h00;
					state                                <= IDLE;
				end

				SEEK_P1:
				if (i_strobe.cmd_wr) begin
					ds                                      <= i_strobe.wdata[0];
					o_seek_cmd[i_strobe.wdata[0]].clear_int <= 1'b1;
					state                                   <= SEEK_P2;
				end

				SEEK_P2:
				if (i_strobe.cmd_wr) begin
					o_seek_cmd[ds].target <= i_strobe.wdata;
					if (seek_ok)
						o_seek_cmd[ds].start <= 1'b1;
					else
						o_seek_cmd[ds].reject <= 1'b1; // seek error
					state <= IDLE;
				end

				// drive 0 has priority
				SENSE_INT_ST0:
				if (i_strobe.data_rd) begin
					o_data_load <= 1'b1;
					if (i_drive_state[0].int_pending) begin
						ds          <= 1'b0;
						o_data_byte <= (i_drive_state[0].at_target && i_drive[0].ready) ?
							`FDC_ST0_SEEK_END : `FDC_ST0_SEEK_ABN;
						state       <= SENSE_INT_PCN;
					end else if (i_drive_state[1].int_pending) begin
						ds          <= 1'b1;
						o_data_byte <= (i_drive_state[1].at_target && i_drive[1].ready) ?
							(`FDC_ST0_SEEK_END | 8'h01) : (`FDC_ST0_SEEK_ABN | 8'h01);
						state       <= SENSE_INT_PCN;
					end else begin
						o_data_byte <= `FDC_ST0_INVALID; // nothing pending
						state       <= IDLE;
					end
				end

				SENSE_INT_PCN:
				if (i_strobe.data_rd) begin
					o_data_load              <= 1'b1;
					o_data_byte              <= sel_state.pcn;
					o_seek_cmd[ds].clear_int <= 1'b1;
					state                    <= IDLE;
				end

				SENSE_DRV_P1:
				if (i_strobe.cmd_wr) begin
					ds    <= i_strobe.wdata[0];
					state <= SENSE_DRV_RES;
				end

				SENSE_DRV_RES:
				if (i_strobe.data_rd) begin
					o_data_load <= 1'b1;
					o_data_byte <= st3;
					state       <= IDLE;
				end

				INVALID_RES:
				if (i_strobe.data_rd) begin
					o_data_load <= 1'b1;
					o_data_byte <= `FDC_ST0_INVALID;
					state       <= IDLE;
				end

				default: state <= IDLE;
			endcase
		end
	end

	// ======================================================================
	// main status register
	// ======================================================================
	assign result_phase = (state == SENSE_INT_ST0) || (state == SENSE_INT_PCN) ||
		(state == SENSE_DRV_RES) || (state == INVALID_RES);

	always_comb begin
		o_msr               = 8'h00;
		o_msr[`FDC_MSR_D0B] = i_drive_state[0].busy;
		o_msr[`FDC_MSR_D1B] = i_drive_state[1].busy;
		o_msr[`FDC_MSR_CB]  = (state != IDLE);
		o_msr[`FDC_MSR_DIO] = result_phase;
		o_msr[`FDC_MSR_RQM] = rqm;
	end

	assign o_step_rate = srt;

endmodule

// File: verilog/fdc_head_stepper.sv
// head positioner of one drive: steps the present cylinder toward the new one, raises seek end
`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_head_stepper #(
	parameter int CYCLES_PER_MS = `FDC_CYCLES_PER_MS_DEFAULT
) (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  fdc_pkg::seek_cmd_t    i_cmd,
	input  fdc_pkg::step_rate_t   i_step_rate,
	output fdc_pkg::drive_state_t o_state
);
	import fdc_pkg::*;

	localparam int MS_W = $clog2(CYCLES_PER_MS + 1);

	seek_state_t     state;
	cyl_t            pcn;      // present cylinder
	cyl_t            ncn;      // new cylinder
	logic            int_pending;
	logic [MS_W-1:0] ms_cnt;
	step_rate_t      unit_cnt; // counts up to Fh

	// ======================================================================
	// seek state machine
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= STEP_IDLE;
			pcn         <= '0;
			ncn         <= '0;
			int_pending <= 1'b0;
			ms_cnt      <= '0;
			unit_cnt    <= '0;
		end else begin
			case (state)
				STEP_IDLE: ;

				STEP_COMPARE: begin
					if (pcn == ncn) begin
						int_pending <= 1'b1; // seek end
						state       <= STEP_IDLE;
					end else begin
						if (pcn > ncn)
							pcn <= pcn - 8'd1;
						else
							pcn <= pcn + 8'd1;
						unit_cnt <= i_step_rate;
						ms_cnt   <= MS_W'(CYCLES_PER_MS);
						state    <= STEP_WAIT;
					end
				end

				// (16 - srt) periods of CYCLES_PER_MS + 1 clocks
				STEP_WAIT: begin
					if (ms_cnt != '0) begin
						ms_cnt <= ms_cnt - 1'b1;
					end else if (unit_cnt != 4'hF) begin
						unit_cnt <= unit_cnt + 4'd1;
						ms_cnt   <= MS_W'(CYCLES_PER_MS);
					end else begin
						state <= STEP_COMPARE;
					end
				end

				default: state <= STEP_IDLE;
			endcase

			if (i_cmd.clear_int)
				int_pending <= 1'b0;

			// a new command overrides whatever runs
			if (i_cmd.start) begin
				ncn         <= i_cmd.target;
				int_pending <= 1'b0;
				state       <= STEP_COMPARE;
			end else if (i_cmd.reject) begin
				ncn         <= i_cmd.target; // head stays put
				int_pending <= 1'b1;
				state       <= STEP_IDLE;
			end
		end
	end

	assign o_state.pcn         = pcn;
	assign o_state.at_target   = (pcn == ncn);
	assign o_state.int_pending = int_pending;
	assign o_state.busy        = (state != STEP_IDLE);

endmodule

// File: verilog/fdc_host_port.sv
// host bus side of the FDC: strobe edge detection, data register and read mux
`timescale 1ns/1ps

module fdc_host_port (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  i_a0,
	input  logic                  i_rd_n,
	input  logic                  i_wr_n,
	input  fdc_pkg::host_byte_t   i_din,
	input  fdc_pkg::host_byte_t   i_msr,
	input  logic                  i_data_load,
	input  fdc_pkg::host_byte_t   i_data_byte,
	output fdc_pkg::host_strobe_t o_strobe,
	output fdc_pkg::host_byte_t   o_dout
);
	import fdc_pkg::*;

	logic       rd_act;
	logic       wr_act;
	logic       rd_act_q;
	logic       wr_act_q;
	logic       rd_pending; // read seen, waiting for a load
	host_byte_t data_reg;

	// a strobe only counts when the other one is idle
	assign rd_act = ~i_rd_n & i_wr_n;
	assign wr_act = ~i_wr_n & i_rd_n;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_act_q   <= 1'b0;
			wr_act_q   <= 1'b0;
			rd_pending <= 1'b0;
		end else begin
			rd_act_q   <= rd_act;
			wr_act_q   <= wr_act;
			rd_pending <= o_strobe.data_rd;
		end
	end

	// pulse on the first clock a strobe is seen low, data register only
	assign o_strobe.cmd_wr  = wr_act & ~wr_act_q & i_a0;
	assign o_strobe.data_rd = rd_act & ~rd_act_q & i_a0;
	assign o_strobe.wdata   = i_din;

	// the command machine answers one clock after the read pulse
	always_ff @(posedge clk_sys) begin
		if (i_data_load)
			data_reg <= i_data_byte;
		else if (rd_pending)
			data_reg <= 8'hFF; // nothing to give
	end

	assign o_dout = i_a0 ? data_reg : i_msr;

endmodule

// File: verilog/fdc_pkg.sv
// shared types of the FDC core, imported by every RTL module
package fdc_pkg;

	typedef logic [7:0] cyl_t;       // cylinder number
	typedef logic       drive_sel_t; // drive select
	typedef logic [3:0] step_rate_t; // SRT field of SPECIFY
	typedef logic [7:0] host_byte_t; // bus data byte

	typedef enum logic [3:0] {
		IDLE,
		SPECIFY_P1,
		SPECIFY_P2,
		RECAL_P1,
		SEEK_P1,
		SEEK_P2,
		SENSE_INT_ST0,
		SENSE_INT_PCN,
		SENSE_DRV_P1,
		SENSE_DRV_RES,
		INVALID_RES
	} cmd_state_t;

	typedef enum logic [1:0] {
		STEP_IDLE,
		STEP_COMPARE,
		STEP_WAIT
	} seek_state_t;

	// static facts about one drive and its medium
	typedef struct packed {
		logic ready;
		logic motor;
		logic available;
		logic write_protect;
		logic two_sided;
		cyl_t track_count;
	} drive_info_t;

	typedef struct packed {
		logic start;     // step toward target
		logic reject;    // flag interrupt, no motion
		logic clear_int;
		cyl_t target;
	} seek_cmd_t;

	typedef struct packed {
		cyl_t pcn;
		logic at_target;
		logic int_pending;
		logic busy;
	} drive_state_t;

	// one-cycle transfer pulses from the bus
	typedef struct packed {
		logic       cmd_wr;
		logic       data_rd;
		host_byte_t wdata;
	} host_strobe_t;

endpackage

// File: verilog/fdc_top.sv
// top of the FDC core: host port, command machine and one head stepper per drive
`timescale 1ns/1ps
`include "fdc_macros.svh"

module fdc_top #(
	parameter int CYCLES_PER_MS = `FDC_CYCLES_PER_MS_DEFAULT
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 i_a0,
	input  logic                 i_rd_n,
	input  logic                 i_wr_n,
	input  fdc_pkg::host_byte_t  i_din,
	input  fdc_pkg::drive_info_t i_drive [2],
	output fdc_pkg::host_byte_t  o_dout
);
	import fdc_pkg::*;

	host_strobe_t strobe;
	host_byte_t   msr;
	host_byte_t   data_byte;
	logic         data_load;
	step_rate_t   step_rate;
	seek_cmd_t    seek_cmd [2];
	drive_state_t drive_state [2];

	fdc_host_port u_host_port (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.i_a0        (i_a0),
		.i_rd_n      (i_rd_n),
		.i_wr_n      (i_wr_n),
		.i_din       (i_din),
		.i_msr       (msr),
		.i_data_load (data_load),
		.i_data_byte (data_byte),
		.o_strobe    (strobe),
		.o_dout      (o_dout)
	);

	fdc_command_fsm u_command_fsm (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.i_strobe      (strobe),
		.i_drive       (i_drive),
		.i_drive_state (drive_state),
		.o_seek_cmd    (seek_cmd),
		.o_step_rate   (step_rate),
		.o_msr         (msr),
		.o_data_load   (data_load),
		.o_data_byte   (data_byte)
	);

	// one stepper per drive, sharing the step rate
	for (genvar d = 0; d < 2; d++) begin : g_drive
		fdc_head_stepper #(
			.CYCLES_PER_MS (CYCLES_PER_MS)
		) u_stepper (
			.clk_sys     (clk_sys),
			.reset       (reset),
			.i_cmd       (seek_cmd[d]),
			.i_step_rate (step_rate),
			.o_state     (drive_state[d])
		);
	end

endmodule
